// File: branch_predict_top.f
+incdir+include
hdl/jump_pkg.sv
hdl/pipe_pkg.sv
hdl/branch_lookup_table.sv
hdl/branch_unit.sv
hdl/fetch_pc.sv
hdl/branch_predict_top.sv
dv/tb_clock_gen.sv
dv/branch_predict_properties.sv
dv/branch_predict_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f branch_predict_top.f \
		--top-module branch_predict_tb

sim:
	verilator --binary --timing --assert -f branch_predict_top.f \
		--top-module branch_predict_tb -o branch_predict_sim
	-./obj_dir/branch_predict_sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/branch_predict_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_config.svh"

module branch_predict_tb;

  import jump_pkg::*;
  import pipe_pkg::*;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`ADDR_WIDTH-`BLT_INDEX_BITS-1:0] tag_t;

  wire clk;
  wire arst_n;

  logic resolve_valid;
  jop_e jop;
  logic zero;
  logic less;
  logic greater;
  addr_t id_ex_pc;
  addr_t id_ex_reg_address;
  addr_t id_ex_imm_address;
  logic branch_taken;
  addr_t branch_taken_address;
  logic fetch_stall;

  addr_t pc;
  logic take_branch;
  addr_t branch_predict;
  flush_mask_t flush;
  addr_t jump_address;

  logic [31:0] rng;
  int errors;
  logic finished;
  addr_t exp_pc;
  logic model_valid [`BLT_ENTRIES];
  tag_t model_tag [`BLT_ENTRIES];
  addr_t model_target [`BLT_ENTRIES];

  tb_clock_gen clock_gen_i (
    .clk    (clk),
    .arst_n (arst_n)
  );

  branch_predict_top branch_predict_top_i (
    .clk                  (clk),
    .arst_n               (arst_n),
    .resolve_valid        (resolve_valid),
    .jop                  (jop),
    .zero                 (zero),
    .less                 (less),
    .greater              (greater),
    .id_ex_pc             (id_ex_pc),
    .id_ex_reg_address    (id_ex_reg_address),
    .id_ex_imm_address    (id_ex_imm_address),
    .branch_taken         (branch_taken),
    .branch_taken_address (branch_taken_address),
    .fetch_stall          (fetch_stall),
    .pc                   (pc),
    .take_branch          (take_branch),
    .branch_predict       (branch_predict),
    .flush                (flush),
    .jump_address         (jump_address)
  );

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  function automatic logic exp_cond(input jop_e op, input logic z, input logic l,
                                    input logic g);
    case (op)
      JOP_JEQ, JOP_JZ:  return z;
      JOP_JNE, JOP_JNZ: return !z;
      JOP_JL:  return l;
      JOP_JLE: return l || z;
      JOP_JG:  return g;
      JOP_JGE: return g || z;
      JOP_JR:  return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic is_branch_op(input jop_e op);
    return op != JOP_NOP && op != JOP_J;
  endfunction

  function automatic flush_mask_t exp_flush(input logic valid, input jop_e op,
                                            input logic cond, input logic bt,
                                            input addr_t bta, input addr_t reg_a,
                                            input addr_t imm_a);
    if (!valid || !is_branch_op(op)) begin
      return '0;
    end else if (op == JOP_JR) begin
      return (bt && bta == reg_a) ? flush_mask_t'('0) : FLUSH_ALL;
    end
    return (cond != bt || (cond && bt && bta != imm_a)) ? FLUSH_ALL : flush_mask_t'('0);
  endfunction

  function automatic addr_t exp_jump_address(input jop_e op, input logic cond,
                                             input logic bt, input addr_t at,
                                             input addr_t reg_a, input addr_t imm_a);
    if (op == JOP_JR) begin
      return reg_a;
    end else if (!cond && bt) begin
      return at + addr_t'(1);
    end
    return imm_a;
  endfunction

  // direct-mapped table model with one entry per low index
  function automatic logic predicted_hit(input addr_t key);
    return model_valid[key[`BLT_INDEX_BITS-1:0]] &&
           model_tag[key[`BLT_INDEX_BITS-1:0]] == key[`ADDR_WIDTH-1:`BLT_INDEX_BITS];
  endfunction

  task automatic record_resolution(input addr_t key, input logic taken, input addr_t target);
    model_valid[key[`BLT_INDEX_BITS-1:0]] = taken;
    if (taken) begin
      model_tag[key[`BLT_INDEX_BITS-1:0]]    = key[`ADDR_WIDTH-1:`BLT_INDEX_BITS];
      model_target[key[`BLT_INDEX_BITS-1:0]] = target;
    end
  endtask

  task automatic fail_run(input string msg);
    errors++;
    finished = 1'b1;
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input addr_t got, input addr_t exp);
    assert (got == exp) else begin
      fail_run($sformatf("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_cycle();
    logic cond;
    logic hit;
    flush_mask_t ef;
    addr_t ej;
    addr_t pred;
    cond = exp_cond(jop, zero, less, greater);
    ef = exp_flush(resolve_valid, jop, cond, branch_taken, branch_taken_address,
                   id_ex_reg_address, id_ex_imm_address);
    ej = exp_jump_address(jop, cond, branch_taken, id_ex_pc, id_ex_reg_address,
                          id_ex_imm_address);
    hit = predicted_hit(pc);
    pred = model_target[pc[`BLT_INDEX_BITS-1:0]];
    check_value("pc", pc, exp_pc);
    check_value("flush", addr_t'(flush), addr_t'(ef));
    check_value("take_branch", addr_t'(take_branch), addr_t'(hit));
    if (resolve_valid) begin
      check_value("jump_address", jump_address, ej);
    end
    if (hit) begin
      check_value("branch_predict", branch_predict, pred);
    end
    // fetch priority is redirect, stall, prediction, then sequential
    if ((ef & PIPE_REG_PC) != '0) begin
      exp_pc = ej;
    end else if (!fetch_stall) begin
      exp_pc = hit ? pred : exp_pc + addr_t'(1);
    end
    if (resolve_valid && is_branch_op(jop)) begin
      record_resolution(id_ex_pc, cond, ej);
    end
  endtask

  always @(negedge clk) begin
    if (!arst_n) begin
      exp_pc = '0;
      foreach (model_valid[i]) model_valid[i] = 1'b0;
    end else begin
      compare_cycle();
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
    resolve_valid = 1'b0;
  endtask

  task automatic strobe(input jop_e op, input logic z, input logic l, input logic g,
                        input addr_t at, input addr_t reg_a, input addr_t imm_a,
                        input logic bt, input addr_t bta);
    next_cycle();
    resolve_valid        = 1'b1;
    jop                  = op;
    zero                 = z;
    less                 = l;
    greater              = g;
    id_ex_pc             = at;
    id_ex_reg_address    = reg_a;
    id_ex_imm_address    = imm_a;
    branch_taken         = bt;
    branch_taken_address = bta;
  endtask

  // mispredicted jr keyed away from the destination's index and tag
  task automatic redirect_to(input addr_t dest, input logic stall);
    strobe(JOP_JR, 1'b0, 1'b0, 1'b0, dest ^ addr_t'(16'h8008), dest, '0, 1'b0, '0);
    fetch_stall = stall;
    @(negedge clk);
    check_value("flush on redirect", addr_t'(flush), addr_t'(FLUSH_ALL));
    next_cycle();
    fetch_stall = 1'b0;
    @(negedge clk);
    check_value("pc after redirect", pc, dest);
  endtask

  task automatic wait_for_pc(input addr_t target_pc);
    int n;
    n = 0;
    do begin
      next_cycle();
      @(negedge clk);
      n++;
    end while (pc != target_pc && n < 64);
    if (pc != target_pc) begin
      fail_run($sformatf("timeout: pc never reached %h", target_pc));
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] r3;
    addr_t a;
    addr_t saved_pc;
    int n;
    rng = 32'h9a58_ef90;
    errors = 0;
    finished = 1'b0;
    resolve_valid = 1'b0;
    jop = JOP_NOP;
    zero = 1'b0;
    less = 1'b0;
    greater = 1'b0;
    id_ex_pc = '0;
    id_ex_reg_address = '0;
    id_ex_imm_address = '0;
    branch_taken = 1'b0;
    branch_taken_address = '0;
    fetch_stall = 1'b0;

    n = 0;
    while (arst_n !== 1'b1 && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (arst_n !== 1'b1) begin
      fail_run("timeout: reset was never released");
    end
    check_value("pc after reset", pc, '0);
    check_value("flush after reset", addr_t'(flush), '0);
    check_value("take_branch after reset", addr_t'(take_branch), '0);

    // sequential fetch, then a stall
    repeat (6) next_cycle();
    fetch_stall = 1'b1;
    next_cycle();
    @(negedge clk);
    saved_pc = pc;
    repeat (3) next_cycle();
    @(negedge clk);
    check_value("pc during stall", pc, saved_pc);
    next_cycle();
    fetch_stall = 1'b0;

    // correctly predicted taken branch allocates, fetch then follows it
    a = pc + addr_t'(6);
    strobe(JOP_JEQ, 1'b1, 1'b0, 1'b0, a, '0, a + addr_t'(16'h0100), 1'b1,
           a + addr_t'(16'h0100));
    wait_for_pc(a);
    check_value("take_branch at branch", addr_t'(take_branch), addr_t'(1));
    next_cycle();
    @(negedge clk);
    check_value("pc after prediction", pc, a + addr_t'(16'h0100));

    // conflicting tag replaces the entry, not taken removes it
    strobe(JOP_JNE, 1'b0, 1'b0, 1'b0, a + addr_t'(16), '0, a + addr_t'(32), 1'b1,
           a + addr_t'(32));
    redirect_to(a, 1'b1);
    check_value("take_branch after replace", addr_t'(take_branch), '0);
    strobe(JOP_JZ, 1'b0, 1'b0, 1'b0, a + addr_t'(16), '0, a + addr_t'(32), 1'b0, '0);
    redirect_to(a + addr_t'(16), 1'b0);
    check_value("take_branch after invalidate", addr_t'(take_branch), '0);

    // random resolutions in a small address window so entries get hit
    for (int i = 0; i < 400; i++) begin
      next_cycle();
      r  = next_rand();
      r2 = next_rand();
      r3 = next_rand();
      resolve_valid        = r[31] | r[30];
      fetch_stall          = r[29] & r[28];
      zero                 = r[27];
      less                 = r[26];
      greater              = r[25];
      branch_taken         = r[24];
      jop                  = jop_e'(4'(r[22:16] % 7'd11));
      id_ex_pc             = addr_t'(r2[31:26]);
      id_ex_reg_address    = addr_t'(r2[25:20]);
      id_ex_imm_address    = addr_t'(r2[19:14]);
      branch_taken_address = addr_t'(r3[31:26]);
      if (r[23]) begin
        branch_taken_address = (jop == JOP_JR) ? id_ex_reg_address : id_ex_imm_address;
      end
    end
    fetch_stall = 1'b0;
    repeat (4) next_cycle();
    @(negedge clk);

    finished = 1'b1;
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  final begin
    if (!finished) begin
      $display("Regression failed");
    end
  end

endmodule

`default_nettype wire

// File: dv/branch_predict_properties.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predict_properties (
  input wire                   clk,
  input wire                   arst_n,
  input wire                   resolve_valid,
  input pipe_pkg::flush_mask_t flush,
  input wire                   blt_write
);

  import pipe_pkg::*;

  flush_needs_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    !resolve_valid |-> flush == '0)
    else $error("flush raised without a resolve strobe");

  // all-or-nothing flush
  flush_shape: assert property (@(posedge clk) disable iff (!arst_n)
    flush == '0 || flush == FLUSH_ALL)
    else $error("flush mask is neither empty nor full");

  write_needs_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    blt_write |-> resolve_valid)
    else $error("table written without a resolve strobe");

endmodule

bind branch_unit branch_predict_properties branch_predict_properties_i (
  .clk           (clk),
  .arst_n        (arst_n),
  .resolve_valid (resolve_valid),
  .flush         (flush),
  .blt_write     (blt_write)
);

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned HALF_PERIOD_NS = 4,
  parameter int unsigned RESET_CYCLES   = 10
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // release just after an edge so it never races the flops
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/branch_predict_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_config.svh"

module branch_predict_top (
  input  wire                       clk,
  input  wire                       arst_n,

  input  wire                       resolve_valid,
  input  jump_pkg::jop_e            jop,
  input  wire                       zero,
  input  wire                       less,
  input  wire                       greater,
  input  wire [`ADDR_WIDTH-1:0]     id_ex_pc,
  input  wire [`ADDR_WIDTH-1:0]     id_ex_reg_address,
  input  wire [`ADDR_WIDTH-1:0]     id_ex_imm_address,
  input  wire                       branch_taken,
  input  wire [`ADDR_WIDTH-1:0]     branch_taken_address,
  input  wire                       fetch_stall,

  output logic [`ADDR_WIDTH-1:0]    pc,
  output logic                      take_branch,
  output logic [`ADDR_WIDTH-1:0]    branch_predict,
  output pipe_pkg::flush_mask_t     flush,
  output logic [`ADDR_WIDTH-1:0]    jump_address
);

  branch_unit branch_unit_i (
    .clk                  (clk),
    .arst_n               (arst_n),
    .resolve_valid        (resolve_valid),
    .jop                  (jop),
    .zero                 (zero),
    .less                 (less),
    .greater              (greater),
    .id_ex_pc             (id_ex_pc),
    .id_ex_reg_address    (id_ex_reg_address),
    .id_ex_imm_address    (id_ex_imm_address),
    .branch_taken         (branch_taken),
    .branch_taken_address (branch_taken_address),
    .pc                   (pc),
    .flush                (flush),
    .jump_address         (jump_address),
    .take_branch          (take_branch),
    .branch_predict       (branch_predict)
  );

  // fetch follows the table prediction unless resolution redirects it
  fetch_pc fetch_pc_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .fetch_stall    (fetch_stall),
    .flush          (flush),
    .jump_address   (jump_address),
    .take_branch    (take_branch),
    .branch_predict (branch_predict),
    .pc             (pc)
  );

endmodule

`default_nettype wire

// File: hdl/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_config.svh"

module fetch_pc (
  input  wire                    clk,
  input  wire                    arst_n,

  input  wire                    fetch_stall,
  input  pipe_pkg::flush_mask_t  flush,
  input  wire [`ADDR_WIDTH-1:0]  jump_address,
  input  wire                    take_branch,
  input  wire [`ADDR_WIDTH-1:0]  branch_predict,

  output logic [`ADDR_WIDTH-1:0] pc
);

  import pipe_pkg::*;

  logic                   redirect;
  logic [`ADDR_WIDTH-1:0] pc_next;

  assign redirect = |(flush & PIPE_REG_PC);

  // redirect wins over stall, stall over prediction
  always_comb begin
    if (redirect) begin
      pc_next = jump_address;
    end else if (fetch_stall) begin
      pc_next = pc;
    end else if (take_branch) begin
      pc_next = branch_predict;
    end else begin
      pc_next = pc + `ADDR_WIDTH'(1);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_config.svh"

module branch_unit (
  input  wire                       clk,
  input  wire                       arst_n,

  input  wire                       resolve_valid,
  input  jump_pkg::jop_e            jop,
  input  wire                       zero,
  input  wire                       less,
  input  wire                       greater,
  input  wire [`ADDR_WIDTH-1:0]     id_ex_pc,
  input  wire [`ADDR_WIDTH-1:0]     id_ex_reg_address,
  input  wire [`ADDR_WIDTH-1:0]     id_ex_imm_address,
  input  wire                       branch_taken,
  input  wire [`ADDR_WIDTH-1:0]     branch_taken_address,

  input  wire [`ADDR_WIDTH-1:0]     pc,

  output pipe_pkg::flush_mask_t     flush,
  output logic [`ADDR_WIDTH-1:0]    jump_address,
  output logic                      take_branch,
  output logic [`ADDR_WIDTH-1:0]    branch_predict
);

  import jump_pkg::*;
  import pipe_pkg::*;

  logic [NUM_FLAGS-1:0] flags;
  logic                 branch_cond;
  logic                 is_branch;
  logic                 dir_miss;
  logic                 target_miss;

  logic                   blt_write;
  logic [`ADDR_WIDTH-1:0] blt_write_key;
  logic [`ADDR_WIDTH-1:0] blt_write_val;
  logic                   blt_hit;

  assign flags[FLAG_ZERO]    = zero;
  assign flags[FLAG_LESS]    = less;
  assign flags[FLAG_GREATER] = greater;

  // condition and branch class from the opcode
  always_comb begin
    branch_cond = 1'b0;
    is_branch   = 1'b1;
    case (jop)
      JOP_JEQ, JOP_JZ:  branch_cond = flags[FLAG_ZERO];
      JOP_JNE, JOP_JNZ: branch_cond = !flags[FLAG_ZERO];
      JOP_JL:  branch_cond = flags[FLAG_LESS];
      JOP_JLE: branch_cond = flags[FLAG_LESS] || flags[FLAG_ZERO];
      JOP_JG:  branch_cond = flags[FLAG_GREATER];
      JOP_JGE: branch_cond = flags[FLAG_GREATER] || flags[FLAG_ZERO];
      JOP_JR:  branch_cond = 1'b1;
      default: is_branch = 1'b0;
    endcase
  end

  // jr has no direction to get wrong, only the target
  always_comb begin
    if (jop == JOP_JR) begin
      dir_miss    = !branch_taken;
      target_miss = branch_taken_address != id_ex_reg_address;
    end else begin
      dir_miss    = branch_cond != branch_taken;
      target_miss = branch_cond && (branch_taken_address != id_ex_imm_address);
    end
  end

  always_comb begin
    flush = '0;
    if (resolve_valid && is_branch && (dir_miss || target_miss)) begin
      flush = FLUSH_ALL;
    end
  end

  always_comb begin
    if (jop == JOP_JR) begin
      jump_address = id_ex_reg_address;
    end else if (!branch_cond && branch_taken) begin
      // predicted taken but falls through
      jump_address = id_ex_pc + `ADDR_WIDTH'(1);
    end else begin
      jump_address = id_ex_imm_address;
    end
  end

  assign blt_write     = resolve_valid && is_branch;
  assign blt_write_key = id_ex_pc;
  assign blt_write_val = jump_address;
  assign blt_hit       = branch_cond;

  branch_lookup_table blt_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .write      (blt_write),
    .write_key  (blt_write_key),
    .write_val  (blt_write_val),
    .hit        (blt_hit),
    .read_key   (pc),
    .read_val   (branch_predict),
    .read_valid (take_branch)
  );

endmodule

`default_nettype wire

// File: hdl/branch_lookup_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_config.svh"

module branch_lookup_table (
  input  wire                    clk,
  input  wire                    arst_n,

  input  wire                    write,
  input  wire [`ADDR_WIDTH-1:0]  write_key,
  input  wire [`ADDR_WIDTH-1:0]  write_val,
  input  wire                    hit,

  input  wire [`ADDR_WIDTH-1:0]  read_key,
  output logic [`ADDR_WIDTH-1:0] read_val,
  output logic                   read_valid
);

  localparam int TAG_BITS = `ADDR_WIDTH - `BLT_INDEX_BITS;

  logic [`BLT_ENTRIES-1:0] valid;
  logic [TAG_BITS-1:0]     tag    [`BLT_ENTRIES];
  logic [`ADDR_WIDTH-1:0]  target [`BLT_ENTRIES];

  logic [`BLT_INDEX_BITS-1:0] wr_idx;
  logic [`BLT_INDEX_BITS-1:0] rd_idx;
  logic [TAG_BITS-1:0]        wr_tag;
  logic [TAG_BITS-1:0]        rd_tag;

  assign wr_idx = write_key[`BLT_INDEX_BITS-1:0];
  assign wr_tag = write_key[`ADDR_WIDTH-1:`BLT_INDEX_BITS];
  assign rd_idx = read_key[`BLT_INDEX_BITS-1:0];
  assign rd_tag = read_key[`ADDR_WIDTH-1:`BLT_INDEX_BITS];

  // taken resolution allocates, not taken invalidates
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
    end else if (write) begin
      valid[wr_idx] <= hit;
    end
  end

  always_ff @(posedge clk) begin
    if (write && hit) begin
      tag[wr_idx]    <= wr_tag;
      target[wr_idx] <= write_val;
    end
  end

  // direct-mapped lookup
  assign read_valid = valid[rd_idx] && (tag[rd_idx] == rd_tag);
  assign read_val   = target[rd_idx];

endmodule

`default_nettype wire

// File: hdl/pipe_pkg.sv
`default_nettype none

`include "branch_config.svh"

package pipe_pkg;

  // one-hot bit per flushable pipeline register
  typedef enum logic [`NUM_PIPE_MASKS-1:0] {
    PIPE_REG_PC     = `NUM_PIPE_MASKS'(1),
    PIPE_REG_IF_ID  = `NUM_PIPE_MASKS'(2),
    PIPE_REG_ID_EX  = `NUM_PIPE_MASKS'(4),
    PIPE_REG_EX_MEM = `NUM_PIPE_MASKS'(8)
  } pipe_reg_e;

  typedef logic [`NUM_PIPE_MASKS-1:0] flush_mask_t;

  localparam flush_mask_t FLUSH_ALL =
    PIPE_REG_PC | PIPE_REG_IF_ID | PIPE_REG_ID_EX | PIPE_REG_EX_MEM;

endpackage

`default_nettype wire

// File: hdl/jump_pkg.sv
`default_nettype none

`include "branch_config.svh"

package jump_pkg;

  // jump opcodes as seen in id/ex
  typedef enum logic [`JUMP_BITS-1:0] {
    JOP_NOP = `JUMP_BITS'(0),
    JOP_J   = `JUMP_BITS'(1),
    JOP_JR  = `JUMP_BITS'(2),
    JOP_JEQ = `JUMP_BITS'(3),
    JOP_JNE = `JUMP_BITS'(4),
    JOP_JL  = `JUMP_BITS'(5),
    JOP_JLE = `JUMP_BITS'(6),
    JOP_JG  = `JUMP_BITS'(7),
    JOP_JGE = `JUMP_BITS'(8),
    JOP_JZ  = `JUMP_BITS'(9),
    JOP_JNZ = `JUMP_BITS'(10)
  } jop_e;

  // alu condition flags, position in the flag vector
  typedef enum int unsigned {
    FLAG_ZERO    = 0,
    FLAG_LESS    = 1,
    FLAG_GREATER = 2
  } cond_flag_e;

  localparam int unsigned NUM_FLAGS = 3;

endpackage

`default_nettype wire

// File: include/branch_config.svh
`ifndef BRANCH_CONFIG_SVH
`define BRANCH_CONFIG_SVH

// instruction address width, addresses count instructions
`define ADDR_WIDTH 16

// branch lookup table geometry
`define BLT_ENTRIES 16
`define BLT_INDEX_BITS 4

`define JUMP_BITS 4

// pc, if/id, id/ex, ex/mem
`define NUM_PIPE_MASKS 4

`endif
